//--- hdl/dcache.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache
  import dcache_pkg::*, mem_bus_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  // load port
  input  logic                 ld_start,
  input  logic [`XLEN-1:0]     ld_addr,
  output logic                 ld_hit,
  output logic [`XLEN-1:0]     ld_data,
  output logic                 ld_stall,
  output logic                 broadcast_valid,
  output logic [`XLEN-1:0]     broadcast_data,
  // store port
  input  logic                 st_valid,
  input  logic [`XLEN-1:0]     st_addr,
  input  logic [`XLEN-1:0]     st_data,
  input  logic [`XLEN/8-1:0]   st_bytes,
  output logic                 st_stall,
  // memory controller
  output bus_command_e         mem_command,
  output logic [`XLEN-1:0]     mem_addr,
  output logic [`LINE_W-1:0]   mem_wdata,
  input  mem_tag_t             mem_response,
  input  logic [`LINE_W-1:0]   mem_rdata,
  input  mem_tag_t             mem_tag
);

  logic [`IDX_W-1:0]    ld_idx;
  logic [`TAG_W-1:0]    ld_tag;
  logic                 ld_upper;
  logic [`IDX_W-1:0]    st_idx;
  logic [`TAG_W-1:0]    st_tag;
  logic [`XLEN-1:0]     st_line_addr;
  logic [`LINE_W-1:0]   st_line_data;
  logic [`LINE_W/8-1:0] st_line_bytes;

  logic                 rd_hit;
  logic [`LINE_W-1:0]   rd_line;
  logic                 st_hit;
  logic                 st_take;
  logic                 fill_en;
  logic [`IDX_W-1:0]    fill_idx;
  logic [`TAG_W-1:0]    fill_tag;
  logic [`LINE_W-1:0]   fill_data;
  logic                 fill_dirty;
  logic                 wb_needed;
  logic [`XLEN-1:0]     wb_addr;
  logic [`LINE_W-1:0]   wb_data;

  logic                 head_retire;
  mshr_entry_t          head_entry;
  logic                 store_pending;
  logic                 free_count_low;
  logic                 full;
  logic                 ld_want;
  logic                 ld_miss;
  logic                 st_miss;

  // a line can hold stale data while a store miss is out
  assign ld_hit  = rd_hit && !store_pending;
  assign ld_data = ld_upper ? rd_line[`LINE_W-1:`XLEN] : rd_line[`XLEN-1:0];

  assign ld_want  = ld_start && !ld_hit;
  assign ld_stall = ld_want && (full || store_pending);
  assign ld_miss  = ld_want && !ld_stall;

  assign st_stall = store_pending || free_count_low;
  assign st_take  = st_valid && !st_stall;
  assign st_miss  = st_take && !st_hit;

  dcache_addr_decode i_decode (
    .ld_addr       (ld_addr),
    .st_valid      (st_valid),
    .st_addr       (st_addr),
    .st_data       (st_data),
    .st_bytes      (st_bytes),
    .ld_idx        (ld_idx),
    .ld_tag        (ld_tag),
    .ld_upper      (ld_upper),
    .st_idx        (st_idx),
    .st_tag        (st_tag),
    .st_line_addr  (st_line_addr),
    .st_line_data  (st_line_data),
    .st_line_bytes (st_line_bytes)
  );

  dcache_mem i_mem (
    .clock         (clock),
    .reset         (reset),
    .ld_idx        (ld_idx),
    .ld_tag        (ld_tag),
    .rd_hit        (rd_hit),
    .rd_line       (rd_line),
    .st_en         (st_take),
    .st_idx        (st_idx),
    .st_tag        (st_tag),
    .st_line_data  (st_line_data),
    .st_line_bytes (st_line_bytes),
    .st_hit        (st_hit),
    .fill_en       (fill_en),
    .fill_idx      (fill_idx),
    .fill_tag      (fill_tag),
    .fill_data     (fill_data),
    .fill_dirty    (fill_dirty),
    .wb_needed     (wb_needed),
    .wb_addr       (wb_addr),
    .wb_data       (wb_data)
  );

  dcache_mshr_queue i_mshr (
    .clock          (clock),
    .reset          (reset),
    .ld_miss        (ld_miss),
    .ld_line_addr   ({ld_addr[`XLEN-1:3], 3'b000}),
    .ld_upper       (ld_upper),
    .st_miss        (st_miss),
    .st_line_addr   (st_line_addr),
    .st_line_data   (st_line_data),
    .st_line_bytes  (st_line_bytes),
    .wb_needed      (wb_needed),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data),
    .mem_response   (mem_response),
    .mem_tag        (mem_tag),
    .mem_command    (mem_command),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .head_retire    (head_retire),
    .head_entry     (head_entry),
    .store_pending  (store_pending),
    .free_count_low (free_count_low),
    .full           (full)
  );

  dcache_refill i_refill (
    .head_retire     (head_retire),
    .head_entry      (head_entry),
    .mem_rdata       (mem_rdata),
    .fill_en         (fill_en),
    .fill_idx        (fill_idx),
    .fill_tag        (fill_tag),
    .fill_data       (fill_data),
    .fill_dirty      (fill_dirty),
    .broadcast_valid (broadcast_valid),
    .broadcast_data  (broadcast_data)
  );

endmodule

`default_nettype wire

//--- hdl/dcache_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_addr_decode (
  input  logic [`XLEN-1:0]     ld_addr,
  input  logic                 st_valid,
  input  logic [`XLEN-1:0]     st_addr,
  input  logic [`XLEN-1:0]     st_data,
  input  logic [`XLEN/8-1:0]   st_bytes,
  output logic [`IDX_W-1:0]    ld_idx,
  output logic [`TAG_W-1:0]    ld_tag,
  output logic                 ld_upper,
  output logic [`IDX_W-1:0]    st_idx,
  output logic [`TAG_W-1:0]    st_tag,
  output logic [`XLEN-1:0]     st_line_addr,
  output logic [`LINE_W-1:0]   st_line_data,
  output logic [`LINE_W/8-1:0] st_line_bytes
);

  // addr = tag | index | half | byte offset
  assign ld_idx   = ld_addr[3 +: `IDX_W];
  assign ld_tag   = ld_addr[`IDX_W+3 +: `TAG_W];
  assign ld_upper = ld_addr[2];

  assign st_idx       = st_addr[3 +: `IDX_W];
  assign st_tag       = st_addr[`IDX_W+3 +: `TAG_W];
  assign st_line_addr = {st_addr[`XLEN-1:3], 3'b000};

  // move the word and its lanes into the addressed half
  always_comb begin
    st_line_data  = '0;
    st_line_bytes = '0;
    if (st_addr[2]) begin
      st_line_data[`LINE_W-1:`XLEN] = st_data;
      st_line_bytes[`LINE_W/8-1:`XLEN/8] = st_bytes;
    end else begin
      st_line_data[`XLEN-1:0] = st_data;
      st_line_bytes[`XLEN/8-1:0] = st_bytes;
    end
    if (!st_valid) begin
      st_line_bytes = '0;  // no lanes without a store
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// word and address width
`define XLEN        32
`define LINE_W      64

// direct mapped array
`define IDX_W       5
`define TAG_W       8
`define LINES       32

// miss queue
`define MSHR_N      16
`define MSHR_PTR_W  4

// controller tag, zero means no response
`define MEM_TAG_W   4

`endif

//--- hdl/dcache_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_mem (
  input  logic                 clock,
  input  logic                 reset,
  // load read
  input  logic [`IDX_W-1:0]    ld_idx,
  input  logic [`TAG_W-1:0]    ld_tag,
  output logic                 rd_hit,
  output logic [`LINE_W-1:0]   rd_line,
  // store write
  input  logic                 st_en,
  input  logic [`IDX_W-1:0]    st_idx,
  input  logic [`TAG_W-1:0]    st_tag,
  input  logic [`LINE_W-1:0]   st_line_data,
  input  logic [`LINE_W/8-1:0] st_line_bytes,
  output logic                 st_hit,
  // refill write
  input  logic                 fill_en,
  input  logic [`IDX_W-1:0]    fill_idx,
  input  logic [`TAG_W-1:0]    fill_tag,
  input  logic [`LINE_W-1:0]   fill_data,
  input  logic                 fill_dirty,
  // displaced line
  output logic                 wb_needed,
  output logic [`XLEN-1:0]     wb_addr,
  output logic [`LINE_W-1:0]   wb_data
);

  logic [`LINE_W-1:0] data_q [`LINES];
  logic [`TAG_W-1:0]  tag_q  [`LINES];
  logic [`LINES-1:0]  valid_q;
  logic [`LINES-1:0]  dirty_q;

  logic [`LINE_W-1:0] st_merged;
  logic               st_same_line;
  logic               fill_same_tag;
  logic               victim_dirty;
  logic               fill_write;

  assign rd_hit  = valid_q[ld_idx] && (tag_q[ld_idx] == ld_tag);
  assign rd_line = data_q[ld_idx];
  assign st_hit  = valid_q[st_idx] && (tag_q[st_idx] == st_tag);

  always_comb begin
    st_merged = data_q[st_idx];
    for (int b = 0; b < `LINE_W/8; b++) begin
      if (st_line_bytes[b]) begin
        st_merged[8*b +: 8] = st_line_data[8*b +: 8];
      end
    end
  end

  // a store hit on the refilled index this cycle belongs to the victim
  assign st_same_line  = st_en && st_hit && (st_idx == fill_idx);
  assign victim_dirty  = dirty_q[fill_idx] || st_same_line;
  assign fill_same_tag = valid_q[fill_idx] && (tag_q[fill_idx] == fill_tag);

  // a dirty copy of the same line is newer than memory, keep it
  assign fill_write = fill_en && !(fill_same_tag && victim_dirty);

  assign wb_needed = fill_en && valid_q[fill_idx] && victim_dirty && !fill_same_tag;
  assign wb_addr   = `XLEN'({tag_q[fill_idx], fill_idx, 3'b000});
  assign wb_data   = st_same_line ? st_merged : data_q[fill_idx];

  // refill comes last so it wins on a shared index
  always_ff @(posedge clock) begin
    if (st_en && st_hit) begin
      data_q[st_idx] <= st_merged;
    end
    if (fill_write) begin
      data_q[fill_idx] <= fill_data;
      tag_q[fill_idx]  <= fill_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (st_en && st_hit) begin
        dirty_q[st_idx] <= 1'b1;
      end
      if (fill_write) begin
        valid_q[fill_idx] <= 1'b1;
        dirty_q[fill_idx] <= fill_dirty;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_mshr_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_mshr_queue
  import dcache_pkg::*, mem_bus_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 ld_miss,
  input  logic [`XLEN-1:0]     ld_line_addr,
  input  logic                 ld_upper,
  input  logic                 st_miss,
  input  logic [`XLEN-1:0]     st_line_addr,
  input  logic [`LINE_W-1:0]   st_line_data,
  input  logic [`LINE_W/8-1:0] st_line_bytes,
  input  logic                 wb_needed,
  input  logic [`XLEN-1:0]     wb_addr,
  input  logic [`LINE_W-1:0]   wb_data,
  input  mem_tag_t             mem_response,
  input  mem_tag_t             mem_tag,
  output bus_command_e         mem_command,
  output logic [`XLEN-1:0]     mem_addr,
  output logic [`LINE_W-1:0]   mem_wdata,
  output logic                 head_retire,
  output mshr_entry_t          head_entry,
  output logic                 store_pending,
  output logic                 free_count_low,
  output logic                 full
);

  mshr_entry_t q [`MSHR_N];

  logic [`MSHR_PTR_W-1:0] head;
  logic [`MSHR_PTR_W-1:0] issue;
  logic [`MSHR_PTR_W-1:0] tail;
  logic [`MSHR_PTR_W-1:0] used;
  logic [`MSHR_PTR_W-1:0] tail_st;
  logic [`MSHR_PTR_W-1:0] tail_wb;
  logic [`MSHR_PTR_W-1:0] tail_next;
  logic                   issue_valid;
  logic                   issue_take;

  // one slot stays empty to tell full from empty
  assign used           = tail - head;
  assign full           = used >= `MSHR_PTR_W'(`MSHR_N - 2);  // room for load + store
  assign free_count_low = used >= `MSHR_PTR_W'(`MSHR_N - 3);

  assign head_entry  = q[head];
  assign head_retire = (head != tail) && head_entry.issued &&
                       (head_entry.command == BUS_STORE || head_entry.mem_tag == mem_tag);

  // command held until the controller answers
  assign issue_valid = (issue != tail) && !q[issue].issued;
  assign issue_take  = issue_valid && (mem_response != '0);
  assign mem_command = issue_valid ? q[issue].command : BUS_NONE;
  assign mem_addr    = q[issue].addr;
  assign mem_wdata   = q[issue].data;

  // append order: load, store, write-back
  always_comb begin
    tail_st   = tail + `MSHR_PTR_W'(ld_miss);
    tail_wb   = tail_st + `MSHR_PTR_W'(st_miss);
    tail_next = tail_wb + `MSHR_PTR_W'(wb_needed);
  end

  always_ff @(posedge clock) begin
    if (issue_take) begin
      q[issue].issued  <= 1'b1;
      q[issue].mem_tag <= mem_response;
    end
    if (ld_miss) begin
      q[tail] <= '{kind: MISS_LOAD, command: BUS_LOAD, addr: ld_line_addr,
                   data: '0, bytes: '0, upper: ld_upper, issued: 1'b0,
                   mem_tag: '0};
    end
    if (st_miss) begin
      q[tail_st] <= '{kind: MISS_STORE, command: BUS_LOAD, addr: st_line_addr,
                      data: st_line_data, bytes: st_line_bytes, upper: 1'b0,
                      issued: 1'b0, mem_tag: '0};
    end
    if (wb_needed) begin
      q[tail_wb] <= '{kind: MISS_WRITEBACK, command: BUS_STORE, addr: wb_addr,
                      data: wb_data, bytes: '1, upper: 1'b0, issued: 1'b0,
                      mem_tag: '0};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head          <= '0;
      issue         <= '0;
      tail          <= '0;
      store_pending <= 1'b0;
    end else begin
      if (head_retire) begin
        head <= head + 1'b1;
      end
      if (issue_take) begin
        issue <= issue + 1'b1;
      end
      tail <= tail_next;
      // at most one store miss in flight
      if (st_miss) begin
        store_pending <= 1'b1;
      end else if (head_retire && head_entry.kind == MISS_STORE) begin
        store_pending <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_pkg.sv
`default_nettype none
`include "dcache_defs.svh"

package dcache_pkg;
  import mem_bus_pkg::*;

  // why an entry sits in the miss queue
  typedef enum logic [1:0] {
    MISS_LOAD      = 2'd0,
    MISS_STORE     = 2'd1,
    MISS_WRITEBACK = 2'd2
  } miss_kind_e;

  typedef struct packed {
    miss_kind_e           kind;
    bus_command_e         command;
    logic [`XLEN-1:0]     addr;     // line aligned
    logic [`LINE_W-1:0]   data;     // store bytes or victim line
    logic [`LINE_W/8-1:0] bytes;    // valid lanes of data
    logic                 upper;    // load word in upper half
    logic                 issued;
    mem_tag_t             mem_tag;  // given on acceptance
  } mshr_entry_t;

endpackage

`default_nettype wire

//--- hdl/dcache_refill.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_refill
  import dcache_pkg::*, mem_bus_pkg::*;
(
  input  logic               head_retire,
  input  mshr_entry_t        head_entry,
  input  logic [`LINE_W-1:0] mem_rdata,
  output logic               fill_en,
  output logic [`IDX_W-1:0]  fill_idx,
  output logic [`TAG_W-1:0]  fill_tag,
  output logic [`LINE_W-1:0] fill_data,
  output logic               fill_dirty,
  output logic               broadcast_valid,
  output logic [`XLEN-1:0]   broadcast_data
);

  logic is_store_miss;

  assign is_store_miss = head_entry.kind == MISS_STORE;

  // only fetched lines go into the array
  assign fill_en  = head_retire && (head_entry.command == BUS_LOAD);
  assign fill_idx = head_entry.addr[3 +: `IDX_W];
  assign fill_tag = head_entry.addr[`IDX_W+3 +: `TAG_W];

  always_comb begin
    fill_data = mem_rdata;
    if (is_store_miss) begin
      for (int b = 0; b < `LINE_W/8; b++) begin
        if (head_entry.bytes[b]) begin
          fill_data[8*b +: 8] = head_entry.data[8*b +: 8];  // pending store wins
        end
      end
    end
  end

  assign fill_dirty = is_store_miss;

  assign broadcast_valid = fill_en && (head_entry.kind == MISS_LOAD);
  assign broadcast_data  = head_entry.upper ? mem_rdata[`LINE_W-1:`XLEN]
                                            : mem_rdata[`XLEN-1:0];

endmodule

`default_nettype wire

//--- hdl/mem_bus_pkg.sv
`default_nettype none
`include "dcache_defs.svh"

package mem_bus_pkg;

  // command toward the memory controller
  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_command_e;

  // response and return tag share this width
  typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

endpackage

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/dcache_pkg.sv
hdl/dcache_addr_decode.sv
hdl/dcache_mem.sv
hdl/dcache_mshr_queue.sv
hdl/dcache_refill.sv
hdl/dcache.sv
testbench/mem_ctrl_model.sv
testbench/dcache_sva.sv
testbench/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module dcache_tb \
  -Mdir obj_dir -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0

//--- testbench/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_sva
  import mem_bus_pkg::*;
(
  input logic                   clock,
  input logic                   reset,
  input bus_command_e           mem_command,
  input mem_tag_t               mem_response,
  input logic                   broadcast_valid,
  input mem_tag_t               head_tag,
  input logic                   ld_stall,
  input logic                   wb_needed,
  input logic [`MSHR_PTR_W-1:0] mshr_tail,
  input logic                   st_stall
);

  // quiet bus and no stalls once reset drops
  property idle_after_reset;
    @(posedge clock) $fell(reset) |->
      (mem_command == BUS_NONE) && !ld_stall && !st_stall && !broadcast_valid;
  endproperty

  // the entry leaves the head as it is broadcast
  property broadcast_once;
    @(posedge clock) disable iff (reset)
      broadcast_valid |=> !broadcast_valid || (head_tag != $past(head_tag));
  endproperty

  // a stalled load adds no entry, only a write-back may land
  property stall_blocks_miss;
    @(posedge clock) disable iff (reset)
      ld_stall |=> mshr_tail == $past(mshr_tail) + `MSHR_PTR_W'($past(wb_needed));
  endproperty

  // command held until the controller answers
  property command_held;
    @(posedge clock) disable iff (reset)
      (mem_command != BUS_NONE) && (mem_response == '0) |=> mem_command == $past(mem_command);
  endproperty

  assert property (idle_after_reset) else $error("bus or stall active after reset");
  assert property (broadcast_once) else $error("broadcast repeated on the same entry");
  assert property (stall_blocks_miss) else $error("load miss accepted during stall");
  assert property (command_held) else $error("bus command dropped before response");

endmodule

bind dcache dcache_sva i_sva (
  .clock           (clock),
  .reset           (reset),
  .mem_command     (mem_command),
  .mem_response    (mem_response),
  .broadcast_valid (broadcast_valid),
  .head_tag        (head_entry.mem_tag),
  .ld_stall        (ld_stall),
  .wb_needed       (wb_needed),
  .mshr_tail       (i_mshr.tail),
  .st_stall        (st_stall)
);

`default_nettype wire

//--- testbench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_tb
  import mem_bus_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;

  logic               clock = 1'b0;
  logic               reset;
  logic               ld_start;
  logic [`XLEN-1:0]   ld_addr;
  logic               ld_hit;
  logic [`XLEN-1:0]   ld_data;
  logic               ld_stall;
  logic               broadcast_valid;
  logic [`XLEN-1:0]   broadcast_data;
  logic               st_valid;
  logic [`XLEN-1:0]   st_addr;
  logic [`XLEN-1:0]   st_data;
  logic [`XLEN/8-1:0] st_bytes;
  logic               st_stall;
  bus_command_e       mem_command;
  logic [`XLEN-1:0]   mem_addr;
  logic [`LINE_W-1:0] mem_wdata;
  mem_tag_t           mem_response;
  logic [`LINE_W-1:0] mem_rdata;
  mem_tag_t           mem_tag;
  int                 accept_delay;
  int                 wb_count;
  logic [`XLEN-1:0]   wb_addr_seen;
  logic [`LINE_W-1:0] wb_data_seen;

  logic [31:0] shadow [logic [31:0]];  // words written by accepted stores
  logic [31:0] pending[$];             // accepted load misses, in order
  int          errors = 0;
  int          checks = 0;
  logic        hung = 1'b0;
  logic        saw_stall = 1'b0;
  logic        saw_ld_stall = 1'b0;
  string       test_name = "reset";

  always #2 clock = ~clock;

  dcache i_dut (.*);

  mem_ctrl_model i_ctrl (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // memory contents before any write-back, same formula as the controller
  function automatic logic [31:0] ref_word(input logic [31:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return (a * 32'h9e3779b1) ^ 32'h5a5a0f0f;
  endfunction

  function automatic logic [31:0] word_addr(input logic [7:0] tag, input logic [4:0] idx,
                                            input logic upper);
    return {16'h0, tag, idx, upper, 2'b00};
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_hang(input string what);
    $display("timeout in %s: %s", test_name, what);
    hung = 1'b1;
  endtask

  // called at 0.5 ns after a rising edge, returns at the same point
  task automatic do_load(input logic [31:0] a, output logic was_hit);
    int t;
    ld_start = 1'b1;
    ld_addr  = a;
    t = 0;
    @(negedge clock);
    while (ld_stall) begin
      t++;
      if (t == WAIT_LIMIT) report_hang("load stall never cleared");
      @(negedge clock);
    end
    was_hit = ld_hit;
    @(posedge clock);
    #0.5;
    ld_start = 1'b0;
  endtask

  task automatic do_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] b);
    int t;
    st_valid = 1'b1;
    st_addr  = a;
    st_data  = d;
    st_bytes = b;
    t = 0;
    @(negedge clock);
    while (st_stall) begin
      t++;
      if (t == WAIT_LIMIT) report_hang("store stall never cleared");
      @(negedge clock);
    end
    @(posedge clock);
    #0.5;
    st_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    @(negedge clock);
    while (pending.size() != 0 || i_dut.i_mshr.head != i_dut.i_mshr.tail) begin
      t++;
      if (t == WAIT_LIMIT) report_hang("miss queue never drained");
      @(negedge clock);
    end
    @(posedge clock);
    #0.5;
  endtask

  // compare hits and broadcasts where the outputs are settled
  always @(negedge clock) begin : compare
    logic [31:0] a;
    logic [31:0] w;
    if (!reset) begin
      if (ld_start && ld_hit) begin
        check_value("load hit", {32'h0, ref_word(ld_addr)}, {32'h0, ld_data});
      end
      if (broadcast_valid) begin
        if (pending.size() == 0) begin
          errors++;
          $display("broadcast with no load miss outstanding in %s", test_name);
        end else begin
          a = pending.pop_front();
          check_value("broadcast", {32'h0, ref_word(a)}, {32'h0, broadcast_data});
        end
      end
      if (ld_start && !ld_hit && !ld_stall) pending.push_back(ld_addr);
      if (st_valid && !st_stall) begin
        w = ref_word(st_addr);
        for (int b = 0; b < 4; b++) begin
          if (st_bytes[b]) w[8*b +: 8] = st_data[8*b +: 8];
        end
        shadow[st_addr] = w;  // cache holds it from the next edge
      end
      if (ld_stall || st_stall) saw_stall = 1'b1;
      if (ld_stall) saw_ld_stall = 1'b1;
    end
  end

  initial begin : watchdog
    while (!hung) @(posedge clock);
    $display("checks=%0d errors=%0d, run stopped on timeout", checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    logic        hit;
    logic [31:0] rnd;
    logic [31:0] a;
    int          wb_before;
    reset        = 1'b1;
    ld_start     = 1'b0;
    ld_addr      = '0;
    st_valid     = 1'b0;
    st_addr      = '0;
    st_data      = '0;
    st_bytes     = '0;
    accept_delay = 0;
    rnd          = 32'hc1c;
    repeat (16) @(posedge clock);
    #0.5;
    reset = 1'b0;

    test_name = "cold_miss";
    do_load(word_addr(8'd1, 5'd3, 1'b0), hit);
    check_value("first access misses", 64'h0, {63'h0, hit});
    wait_idle();
    do_load(word_addr(8'd1, 5'd3, 1'b0), hit);
    check_value("repeat hits", 64'h1, {63'h0, hit});
    do_load(word_addr(8'd1, 5'd3, 1'b1), hit);
    check_value("other half hits", 64'h1, {63'h0, hit});

    test_name = "store_hit";
    do_store(word_addr(8'd1, 5'd3, 1'b0), 32'h11223344, 4'b0101);
    do_store(word_addr(8'd1, 5'd3, 1'b1), 32'haabbccdd, 4'b1000);
    do_load(word_addr(8'd1, 5'd3, 1'b0), hit);
    check_value("lower hit", 64'h1, {63'h0, hit});
    do_load(word_addr(8'd1, 5'd3, 1'b1), hit);
    check_value("upper hit", 64'h1, {63'h0, hit});

    test_name = "store_miss";
    do_store(word_addr(8'd2, 5'd7, 1'b1), 32'h0badcafe, 4'b0011);
    saw_ld_stall = 1'b0;
    do_load(word_addr(8'd2, 5'd7, 1'b1), hit);  // stalls until the line is in
    check_value("load stalled", 64'h1, {63'h0, saw_ld_stall});
    check_value("merged line hits", 64'h1, {63'h0, hit});
    wait_idle();

    test_name = "write_back";
    wb_before = wb_count;
    do_load(word_addr(8'd9, 5'd7, 1'b0), hit);
    wait_idle();
    check_value("one write-back", 64'(wb_before + 1), 64'(wb_count));
    check_value("victim address", {32'h0, word_addr(8'd2, 5'd7, 1'b0)}, {32'h0, wb_addr_seen});
    check_value("victim data", {ref_word(word_addr(8'd2, 5'd7, 1'b1)),
                                ref_word(word_addr(8'd2, 5'd7, 1'b0))}, wb_data_seen);
    do_load(word_addr(8'd2, 5'd7, 1'b1), hit);
    check_value("old line misses", 64'h0, {63'h0, hit});
    wait_idle();

    test_name = "random_burst";
    accept_delay = 6;
    saw_stall    = 1'b0;
    for (int i = 0; i < 48; i++) begin
      rnd = lcg_next(rnd);
      if (rnd[3:0] < 4'd11) begin
        // loads and stores use disjoint tags
        a = word_addr(8'h10 + {4'h0, rnd[7:4]}, rnd[12:8], rnd[13]);
        do_load(a, hit);
      end else begin
        a = word_addr(8'h40 + {4'h0, rnd[7:4]}, rnd[12:8], rnd[13]);
        do_store(a, lcg_next(rnd), rnd[19:16]);
      end
    end
    wait_idle();
    accept_delay = 0;
    check_value("stall raised", 64'h1, {63'h0, saw_stall});

    repeat (4) @(posedge clock);
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/mem_ctrl_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module mem_ctrl_model
  import mem_bus_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  int                 accept_delay,  // cycles a command waits
  input  bus_command_e       mem_command,
  input  logic [`XLEN-1:0]   mem_addr,
  input  logic [`LINE_W-1:0] mem_wdata,
  output mem_tag_t           mem_response,
  output logic [`LINE_W-1:0] mem_rdata,
  output mem_tag_t           mem_tag,
  output int                 wb_count,
  output logic [`XLEN-1:0]   wb_addr_seen,
  output logic [`LINE_W-1:0] wb_data_seen
);

  logic [`LINE_W-1:0] lines [logic [`XLEN-1:0]];  // only written lines
  int                 ret_due[$];
  mem_tag_t           ret_tag[$];
  logic [`LINE_W-1:0] ret_data[$];
  int                 cycle;
  int                 waited;
  int                 last_due;
  int                 due;
  logic [31:0]        seed;
  mem_tag_t           next_tag;

  function automatic logic [31:0] mem_init_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ 32'h5a5a0f0f;
  endfunction

  function automatic logic [63:0] read_line(input logic [31:0] a);
    if (lines.exists(a)) begin
      return lines[a];
    end
    return {mem_init_word(a + 32'd4), mem_init_word(a)};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    mem_response = '0;
    mem_tag      = '0;
    mem_rdata    = '0;
    wb_count     = 0;
    wb_addr_seen = '0;
    wb_data_seen = '0;
    forever begin
      @(posedge clock);
      #0.5;
      mem_response = '0;
      mem_tag      = '0;
      if (reset) begin
        lines.delete();
        ret_due.delete();
        ret_tag.delete();
        ret_data.delete();
        cycle    = 0;
        waited   = 0;
        last_due = 0;
        seed     = 32'hc1c;
        next_tag = 4'd1;  // zero means no response
        wb_count = 0;
      end else begin
        cycle++;
        if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
          mem_tag   = ret_tag.pop_front();
          mem_rdata = ret_data.pop_front();
          void'(ret_due.pop_front());
        end
        if (mem_command != BUS_NONE) begin
          if (waited >= accept_delay) begin
            mem_response = next_tag;
            if (mem_command == BUS_LOAD) begin
              seed = lcg_next(seed);
              due  = cycle + 2 + int'(seed[17:16]);
              if (due <= last_due) begin
                due = last_due + 1;  // keep returns in order
              end
              last_due = due;
              ret_due.push_back(due);
              ret_tag.push_back(next_tag);
              ret_data.push_back(read_line(mem_addr));
            end else begin
              lines[mem_addr] = mem_wdata;
              wb_count++;
              wb_addr_seen = mem_addr;
              wb_data_seen = mem_wdata;
            end
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            waited   = 0;
          end else begin
            waited++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire
